// ==== rtl/sc_cfg_pkg.sv ====
/*
  Settings bus map for the synchronizer.
  Writes use i_set_stb with an 8-bit address and 32-bit data. Each field
  takes the low bits of the data word. The threshold is unsigned Q2.6.
*/
package sc_cfg_pkg;

  localparam int SET_ADDR_W    = 8;
  localparam int SET_DATA_W    = 32;
  localparam int THRESH_FRAC_W = 6;  // Fraction bits of the threshold

  localparam logic [SET_ADDR_W-1:0] ADDR_THRESHOLD  = 8'd0;
  localparam logic [SET_ADDR_W-1:0] ADDR_PLATEAU    = 8'd1;
  localparam logic [SET_ADDR_W-1:0] ADDR_FRAME      = 8'd2;
  localparam logic [SET_ADDR_W-1:0] ADDR_MIN_ENERGY = 8'd3;

  typedef logic [7:0]  thresh_t;
  typedef logic [7:0]  plat_len_t;
  typedef logic [15:0] frame_len_t;
  typedef logic [31:0] min_energy_t;  // Compared against the combined R

  // Values after reset
  localparam thresh_t     RESET_THRESHOLD  = 8'h30;  // 0.75
  localparam plat_len_t   RESET_PLATEAU    = 8'd8;
  localparam frame_len_t  RESET_FRAME      = 16'd32;
  localparam min_energy_t RESET_MIN_ENERGY = 32'd1000;

endpackage

// ==== rtl/sc_corr_lane.sv ====
/*
  One antenna's correlation lane.
  Products are registered one cycle after the feed, the window sums one cycle
  later. The sums are kept as running add/subtract over a ring of the last
  WINDOW_LEN terms; the ring resets to zero so sums start from an empty window.
*/
module sc_corr_lane #(
  parameter int WINDOW_LEN = 16
) (
  input  logic                    clk,
  input  logic                    i_rst,
  input  sc_types_pkg::feed_t     i_feed,
  input  logic                    i_valid,
  output sc_types_pkg::lane_out_t o_lane,
  output logic                    o_valid
);

  localparam int PTR_W = $clog2(WINDOW_LEN);

  sc_types_pkg::cprod_t  prod_q;
  sc_types_pkg::energy_t nrg_q;
  sc_types_pkg::cplx_t   samp_q;
  logic                  prod_valid;
  sc_types_pkg::cprod_t  prod_ring [WINDOW_LEN];
  sc_types_pkg::energy_t nrg_ring  [WINDOW_LEN];
  logic [PTR_W-1:0]      rptr;
  sc_types_pkg::acc_t    sum_re;
  sc_types_pkg::acc_t    sum_im;
  sc_types_pkg::acc_t    sum_e;
  sc_types_pkg::cplx_t   samp_out;

  // (a + jb)(c - jd) = (ac + bd) + j(bc - ad)
  always_ff @(posedge clk) begin
    if (i_valid) begin
      prod_q.re <= i_feed.cur.re * i_feed.dly.re + i_feed.cur.im * i_feed.dly.im;
      prod_q.im <= i_feed.cur.im * i_feed.dly.re - i_feed.cur.re * i_feed.dly.im;
      nrg_q     <= i_feed.cur.re * i_feed.cur.re + i_feed.cur.im * i_feed.cur.im;
      samp_q    <= i_feed.cur;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      prod_valid <= 1'b0;
      o_valid    <= 1'b0;
      rptr       <= '0;
      sum_re     <= '0;
      sum_im     <= '0;
      sum_e      <= '0;
      for (int i = 0; i < WINDOW_LEN; i++) begin
        prod_ring[i] <= '0;
        nrg_ring[i]  <= '0;
      end
    end else begin
      prod_valid <= i_valid;
      o_valid    <= prod_valid;
      if (prod_valid) begin
        sum_re          <= sum_re + prod_q.re - prod_ring[rptr].re;
        sum_im          <= sum_im + prod_q.im - prod_ring[rptr].im;
        sum_e           <= sum_e + nrg_q - nrg_ring[rptr];  // Oldest term leaves
        prod_ring[rptr] <= prod_q;
        nrg_ring[rptr]  <= nrg_q;
        rptr            <= (rptr == PTR_W'(WINDOW_LEN - 1)) ? '0 : rptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      samp_out <= samp_q;
    end
  end

  assign o_lane = '{corr_re: sum_re, corr_im: sum_im, energy: sum_e, sample: samp_out};

  a_energy_nonneg: assert property (@(posedge clk) disable iff (i_rst)
    !sum_e[$bits(sc_types_pkg::acc_t)-1])
    else $error("window energy went negative");

endmodule

// ==== rtl/sc_delay_feeder.sv ====
/*
  Delay feeder for the correlation lanes.
  One input register, then a circular buffer of WINDOW_LEN sample vectors
  shared by all antennas. The buffer resets to zero, so dly is zero for the
  first WINDOW_LEN samples after reset. WINDOW_LEN must be at least 2.
  No back-pressure; a gap in the stream is i_valid low.
*/
module sc_delay_feeder #(
  parameter int WINDOW_LEN = 16,
  parameter int NUM_ANT    = 2
) (
  input  logic                              clk,
  input  logic                              i_rst,
  input  sc_types_pkg::cplx_t [NUM_ANT-1:0] i_samples,
  input  logic                              i_valid,
  output sc_types_pkg::feed_t [NUM_ANT-1:0] o_feed,
  output logic                              o_feed_valid
);

  localparam int PTR_W = $clog2(WINDOW_LEN);

  typedef sc_types_pkg::cplx_t [NUM_ANT-1:0] vec_t;

  vec_t             in_q;
  logic             in_valid_q;
  vec_t             hist [WINDOW_LEN];
  logic [PTR_W-1:0] wptr;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      in_valid_q <= 1'b0;
    end else begin
      in_valid_q <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid) begin
      in_q <= i_samples;
    end
  end

  // Slot at wptr holds the vector from WINDOW_LEN samples ago
  always_ff @(posedge clk) begin
    if (i_rst) begin
      wptr         <= '0;
      o_feed_valid <= 1'b0;
      for (int i = 0; i < WINDOW_LEN; i++) begin
        hist[i] <= '0;
      end
    end else begin
      o_feed_valid <= in_valid_q;
      if (in_valid_q) begin
        hist[wptr] <= in_q;
        wptr       <= (wptr == PTR_W'(WINDOW_LEN - 1)) ? '0 : wptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_q) begin
      for (int a = 0; a < NUM_ANT; a++) begin
        o_feed[a].cur <= in_q[a];
        o_feed[a].dly <= hist[wptr][a];  // Read before overwrite
      end
    end
  end

  a_wptr_range: assert property (@(posedge clk) disable iff (i_rst)
    32'(wptr) < WINDOW_LEN)
    else $error("feeder write pointer out of range");

endmodule

// ==== rtl/sc_frame_gate.sv ====
/*
  Settings registers, plateau counter and frame gate.
  A write lands on the cycle after i_set_stb. Plateau and frame lengths of 0
  act as 1. Hits are ignored inside a frame and the plateau count restarts
  from zero once the frame ends. Only framed samples raise o_valid.
*/
module sc_frame_gate (
  input  logic                                clk,
  input  logic                                i_rst,
  input  logic                                i_set_stb,
  input  logic [sc_cfg_pkg::SET_ADDR_W-1:0]   i_set_addr,
  input  logic [sc_cfg_pkg::SET_DATA_W-1:0]   i_set_data,
  input  logic                                i_hit,
  input  sc_types_pkg::cplx_t                 i_sample,
  input  logic                                i_valid,
  output sc_cfg_pkg::thresh_t                 o_threshold,
  output sc_cfg_pkg::min_energy_t             o_min_energy,
  output sc_types_pkg::cplx_t                 o_data,
  output logic                                o_valid,
  output logic                                o_sof,
  output logic                                o_eof
);

  typedef enum logic {
    GATE_IDLE,
    GATE_FRAME
  } gate_state_t;

  gate_state_t                             state;
  sc_cfg_pkg::thresh_t                     threshold;
  sc_cfg_pkg::plat_len_t                   plateau_len;
  sc_cfg_pkg::frame_len_t                  frame_len;
  sc_cfg_pkg::min_energy_t                 min_energy;
  sc_cfg_pkg::plat_len_t                   plat_cnt;
  sc_cfg_pkg::frame_len_t                  frame_cnt;  // Samples passed so far
  logic [$bits(sc_cfg_pkg::plat_len_t):0]  plat_next;
  logic [$bits(sc_cfg_pkg::frame_len_t):0] frame_next;
  logic                                    plateau_done;
  logic                                    frame_done;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      threshold   <= sc_cfg_pkg::RESET_THRESHOLD;
      plateau_len <= sc_cfg_pkg::RESET_PLATEAU;
      frame_len   <= sc_cfg_pkg::RESET_FRAME;
      min_energy  <= sc_cfg_pkg::RESET_MIN_ENERGY;
    end else if (i_set_stb) begin
      case (i_set_addr)
        sc_cfg_pkg::ADDR_THRESHOLD:  threshold   <= sc_cfg_pkg::thresh_t'(i_set_data);
        sc_cfg_pkg::ADDR_PLATEAU:    plateau_len <= sc_cfg_pkg::plat_len_t'(i_set_data);
        sc_cfg_pkg::ADDR_FRAME:      frame_len   <= sc_cfg_pkg::frame_len_t'(i_set_data);
        sc_cfg_pkg::ADDR_MIN_ENERGY: min_energy  <= sc_cfg_pkg::min_energy_t'(i_set_data);
        default: ;  // Unmapped addresses are dropped
      endcase
    end
  end

  assign o_threshold  = threshold;
  assign o_min_energy = min_energy;

  // >= so a length lowered mid-count still closes
  assign plat_next    = plat_cnt + 1'b1;
  assign frame_next   = frame_cnt + 1'b1;
  assign plateau_done = plat_next >= plateau_len;
  assign frame_done   = frame_next >= frame_len;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state     <= GATE_IDLE;
      plat_cnt  <= '0;
      frame_cnt <= '0;
      o_valid   <= 1'b0;
      o_sof     <= 1'b0;
      o_eof     <= 1'b0;
    end else begin
      o_valid <= 1'b0;
      o_sof   <= 1'b0;
      o_eof   <= 1'b0;
      if (i_valid) begin
        if (state == GATE_IDLE && !i_hit) begin
          plat_cnt <= '0;
        end else if (state == GATE_IDLE && !plateau_done) begin
          plat_cnt <= plat_cnt + 1'b1;
        end else begin
          // Sample passes once the plateau is reached or a frame runs
          o_valid   <= 1'b1;
          o_sof     <= (state == GATE_IDLE);
          o_eof     <= frame_done;
          plat_cnt  <= '0;
          frame_cnt <= frame_done ? '0 : frame_cnt + 1'b1;
          state     <= frame_done ? GATE_IDLE : GATE_FRAME;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid) begin
      o_data <= i_sample;
    end
  end

  a_sof_valid: assert property (@(posedge clk) disable iff (i_rst)
    o_sof |-> (o_valid && $past(i_valid && i_hit)))
    else $error("sof without valid or without a hit");

  // eof closes a frame that was open, or a one-sample frame
  a_eof_in_frame: assert property (@(posedge clk) disable iff (i_rst)
    o_eof |-> (o_sof || $past(state) == GATE_FRAME))
    else $error("eof while gate idle");

endmodule

// ==== rtl/sc_lane_combiner.sv ====
/*
  Lane combiner and metric test.
  Hit when |Re P| + |Im P| >= (threshold * R) >> 6 and R >= min_energy.
  This stands in for |P|/R without a divider, so the threshold is on the
  L1 magnitude of P and reads slightly high against the true metric.
*/
module sc_lane_combiner #(
  parameter int NUM_ANT = 2
) (
  input  logic                                  clk,
  input  logic                                  i_rst,
  input  sc_types_pkg::lane_out_t [NUM_ANT-1:0] i_lanes,
  input  logic [NUM_ANT-1:0]                    i_valid,
  input  sc_cfg_pkg::thresh_t                   i_threshold,
  input  sc_cfg_pkg::min_energy_t               i_min_energy,
  output logic                                  o_hit,
  output sc_types_pkg::cplx_t                   o_sample,
  output logic                                  o_valid
);

  localparam int ACC_W = $bits(sc_types_pkg::acc_t);
  localparam int THR_W = $bits(sc_cfg_pkg::thresh_t);

  sc_types_pkg::acc_t     p_re;
  sc_types_pkg::acc_t     p_im;
  sc_types_pkg::acc_t     r_sum;
  logic [ACC_W-1:0]       abs_re;
  logic [ACC_W-1:0]       abs_im;
  logic [ACC_W:0]         corr_l1;
  logic [ACC_W+THR_W-1:0] r_scaled;
  logic                   corr_ok;
  logic                   energy_ok;

  always_comb begin
    p_re  = '0;
    p_im  = '0;
    r_sum = '0;
    for (int a = 0; a < NUM_ANT; a++) begin
      p_re  += i_lanes[a].corr_re;
      p_im  += i_lanes[a].corr_im;
      r_sum += i_lanes[a].energy;
    end
    abs_re    = p_re[ACC_W-1] ? -p_re : p_re;
    abs_im    = p_im[ACC_W-1] ? -p_im : p_im;
    corr_l1   = {1'b0, abs_re} + {1'b0, abs_im};
    r_scaled  = $unsigned(r_sum) * i_threshold;  // Q2.6 product
    corr_ok   = corr_l1 >= (r_scaled >> sc_cfg_pkg::THRESH_FRAC_W);
    energy_ok = $unsigned(r_sum) >= i_min_energy;
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
      o_hit   <= 1'b0;
    end else begin
      o_valid <= i_valid[0];
      o_hit   <= i_valid[0] && corr_ok && energy_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid[0]) begin
      o_sample <= i_lanes[0].sample;  // Antenna 0 goes on to the gate
    end
  end

  // Lanes share one feed strobe, so they must stay in lock step
  a_lanes_aligned: assert property (@(posedge clk) disable iff (i_rst)
    (&i_valid) || !(|i_valid))
    else $error("lane valids disagree");

endmodule

// ==== rtl/sc_sync_top.sv ====
/*
  Two-antenna Schmidl-Cox frame synchronizer.
  Fixed 5-cycle latency from the sampling edge of i_valid to o_valid.
  Only samples inside a detected frame come out; o_data is antenna 0.
  No back-pressure and no frequency-offset correction.
*/
module sc_sync_top #(
  parameter int WINDOW_LEN = 16,
  parameter int NUM_ANT    = 2
) (
  input  logic                              clk,
  input  logic                              i_rst,
  input  sc_types_pkg::cplx_t [NUM_ANT-1:0] i_samples,
  input  logic                              i_valid,
  input  logic                              i_set_stb,
  input  logic [sc_cfg_pkg::SET_ADDR_W-1:0] i_set_addr,
  input  logic [sc_cfg_pkg::SET_DATA_W-1:0] i_set_data,
  output sc_types_pkg::cplx_t               o_data,
  output logic                              o_valid,
  output logic                              o_sof,
  output logic                              o_eof
);

  sc_types_pkg::feed_t [NUM_ANT-1:0]     feed;
  logic                                  feed_valid;
  sc_types_pkg::lane_out_t [NUM_ANT-1:0] lane_out;
  logic [NUM_ANT-1:0]                    lane_valid;
  logic                                  hit;
  sc_types_pkg::cplx_t                   cmb_sample;
  logic                                  cmb_valid;
  sc_cfg_pkg::thresh_t                   threshold;
  sc_cfg_pkg::min_energy_t               min_energy;

  sc_delay_feeder #(
    .WINDOW_LEN (WINDOW_LEN),
    .NUM_ANT    (NUM_ANT)
  ) u_feeder (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_samples    (i_samples),
    .i_valid      (i_valid),
    .o_feed       (feed),
    .o_feed_valid (feed_valid)
  );

  for (genvar a = 0; a < NUM_ANT; a++) begin : g_lane
    sc_corr_lane #(
      .WINDOW_LEN (WINDOW_LEN)
    ) u_lane (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_feed  (feed[a]),
      .i_valid (feed_valid),
      .o_lane  (lane_out[a]),
      .o_valid (lane_valid[a])
    );
  end

  sc_lane_combiner #(
    .NUM_ANT (NUM_ANT)
  ) u_combiner (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_lanes      (lane_out),
    .i_valid      (lane_valid),
    .i_threshold  (threshold),
    .i_min_energy (min_energy),
    .o_hit        (hit),
    .o_sample     (cmb_sample),
    .o_valid      (cmb_valid)
  );

  sc_frame_gate u_gate (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_set_stb    (i_set_stb),
    .i_set_addr   (i_set_addr),
    .i_set_data   (i_set_data),
    .i_hit        (hit),
    .i_sample     (cmb_sample),
    .i_valid      (cmb_valid),
    .o_threshold  (threshold),
    .o_min_energy (min_energy),
    .o_data       (o_data),
    .o_valid      (o_valid),
    .o_sof        (o_sof),
    .o_eof        (o_eof)
  );

endmodule

// ==== rtl/sc_types_pkg.sv ====
/*
  Datapath types for the Schmidl-Cox synchronizer.
  Samples are signed 16-bit I/Q. A full-scale pair of -32768 samples can wrap
  the 32-bit conjugate product, so inputs are expected to stay off the rail.
  The sum guard covers WINDOW_LEN up to 64 and NUM_ANT up to 4.
*/
package sc_types_pkg;

  localparam int SUM_GUARD = 8;

  typedef logic signed [15:0] sample_t;

  typedef struct packed {
    sample_t re;
    sample_t im;
  } cplx_t;

  typedef logic signed [31:0] prod_t;

  typedef struct packed {
    prod_t re;
    prod_t im;
  } cprod_t;

  typedef logic [31:0] energy_t;  // |x|^2, never negative

  typedef logic signed [$bits(prod_t)+SUM_GUARD-1:0] acc_t;

  // One lane's window sums plus the sample they line up with
  typedef struct packed {
    acc_t  corr_re;
    acc_t  corr_im;
    acc_t  energy;
    cplx_t sample;
  } lane_out_t;

  typedef struct packed {
    cplx_t cur;
    cplx_t dly;  // Sample from WINDOW_LEN valids earlier
  } feed_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# A failing check ends in $fatal, which gives a nonzero exit status.
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
  --top-module tb_sc_sync \
  -f tb.f \
  -o Vtb_sc_sync

./obj_dir/Vtb_sc_sync

// ==== tb.f ====
+incdir+verif
rtl/sc_types_pkg.sv
rtl/sc_cfg_pkg.sv
rtl/sc_delay_feeder.sv
rtl/sc_corr_lane.sv
rtl/sc_lane_combiner.sv
rtl/sc_frame_gate.sv
rtl/sc_sync_top.sv
verif/tb_sc_sync.sv

// ==== verif/sc_ref_model.svh ====
/*
  Reference model for the synchronizer testbench.
  Works on the full input history held in ant_re/ant_im of the including
  module. Samples before index 0 count as zero, as after a DUT reset.
*/
`ifndef SC_REF_MODEL_SVH
`define SC_REF_MODEL_SVH

// P and R summed over all antennas for the window ending at sample n
function automatic void window_sums(input int n, output longint p_re, output longint p_im,
                                    output longint r);
  longint a, b, c, d;
  p_re = 0;
  p_im = 0;
  r    = 0;
  for (int ant = 0; ant < NUM_ANT; ant++) begin
    for (int m = n - WINDOW_LEN + 1; m <= n; m++) begin
      a = (m >= 0) ? ant_re[ant][m] : 0;
      b = (m >= 0) ? ant_im[ant][m] : 0;
      c = (m - WINDOW_LEN >= 0) ? ant_re[ant][m-WINDOW_LEN] : 0;
      d = (m - WINDOW_LEN >= 0) ? ant_im[ant][m-WINDOW_LEN] : 0;
      p_re += a * c + b * d;  // x(m) times conj of x(m-W)
      p_im += b * c - a * d;
      r    += a * a + b * b;
    end
  end
endfunction

function automatic bit metric_hit(input int n, input longint thr, input longint min_e);
  longint p_re, p_im, r, l1;
  window_sums(n, p_re, p_im, r);
  l1 = ((p_re < 0) ? -p_re : p_re) + ((p_im < 0) ? -p_im : p_im);
  return (l1 >= ((thr * r) >>> 6)) && (r >= min_e);
endfunction

// Framing rule applied to the hit sequence; fills exp_* for each input index
function automatic int build_expected(input int total, input longint thr, input longint min_e,
                                      input int plat, input int flen);
  int  plat_cnt;
  int  frame_cnt;
  bit  in_frame;
  int  count;
  plat_cnt  = 0;
  frame_cnt = 0;
  in_frame  = 0;
  count     = 0;
  for (int n = 0; n < total; n++) begin
    exp_valid[n] = 0;
    exp_sof[n]   = 0;
    exp_eof[n]   = 0;
    if (!in_frame) begin
      if (!metric_hit(n, thr, min_e)) begin
        plat_cnt = 0;
      end else if (plat_cnt + 1 >= plat) begin
        in_frame   = 1;
        plat_cnt   = 0;
        exp_sof[n] = 1;
      end else begin
        plat_cnt++;
      end
    end
    if (in_frame) begin
      exp_valid[n] = 1;
      count++;
      if (frame_cnt + 1 >= flen) begin
        exp_eof[n] = 1;
        in_frame   = 0;
        frame_cnt  = 0;
      end else begin
        frame_cnt++;
      end
    end
  end
  return count;
endfunction

`endif

// ==== verif/tb_sc_sync.sv ====
/*
  Testbench for the Schmidl-Cox synchronizer.
  Each table row resets the DUT, writes the settings and streams one burst.
  Outputs are mapped back to input indices through the fixed 5-cycle latency.
*/
module tb_sc_sync;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WINDOW_LEN = 16;
  localparam int NUM_ANT    = 2;
  localparam int LATENCY    = 5;
  localparam int MAX_LEN    = 512;
  localparam int NUM_ROWS   = 6;

  typedef struct {
    int     pre_amp;
    int     pre_start;
    int     repeats;
    int     noise_amp;
    int     thresh;
    int     plateau;
    int     frame_len;
    longint min_e;
    int     total;
    int     gap_period;  // One idle cycle every gap_period samples or 0 for none
    bit     expect_frame;
  } row_t;

  logic                              clk = 1'b0;
  logic                              i_rst = 1'b1;
  sc_types_pkg::cplx_t [NUM_ANT-1:0] i_samples = '0;
  logic                              i_valid = 1'b0;
  logic                              i_set_stb = 1'b0;
  logic [7:0]                        i_set_addr = '0;
  logic [31:0]                       i_set_data = '0;
  sc_types_pkg::cplx_t               o_data;
  logic                              o_valid;
  logic                              o_sof;
  logic                              o_eof;

  row_t   rows [NUM_ROWS];
  int     ant_re [NUM_ANT][MAX_LEN];
  int     ant_im [NUM_ANT][MAX_LEN];
  bit     exp_valid [MAX_LEN];
  bit     exp_sof [MAX_LEN];
  bit     exp_eof [MAX_LEN];
  int     idx_at [int];
  int     seed = 32'h730c;
  int     drv_idx = 0;
  int     cyc = 0;
  int     cycle_limit = 1000000;
  int     out_count;
  int     sof_count;
  bit     rst_seen = 1'b1;

  `include "sc_ref_model.svh"

  sc_sync_top #(.WINDOW_LEN(WINDOW_LEN), .NUM_ANT(NUM_ANT)) dut (.*);

  always #20 clk = ~clk;

  task automatic check_val(input string name, input longint got, input longint exp);
    if (got != exp) begin
      $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "check on %s failed", name);
    end
  endtask

  function automatic int rnd(input int amp);
    if (amp == 0) return 0;
    return $random(seed) % (amp + 1);
  endfunction

  // Cycle count, input index per sampling edge, timeout
  always @(posedge clk) begin
    cyc      = cyc + 1;
    rst_seen = i_rst;
    if (i_valid) idx_at[cyc] = drv_idx;
    if (cyc > cycle_limit) begin
      $display("Simulation FAILED");
      $fatal(1, "timeout after %0d cycles without finishing the tests", cyc);
    end
  end

  always @(negedge clk) begin
    int idx;
    if (i_rst || rst_seen) begin
      check_val("o_valid", o_valid, 0);
      check_val("o_sof", o_sof, 0);
      check_val("o_eof", o_eof, 0);
    end else if (o_valid) begin
      if (!idx_at.exists(cyc - LATENCY)) begin
        $display("Simulation FAILED");
        $fatal(1, "output valid came with no input sample five cycles before it");
      end
      idx = idx_at[cyc - LATENCY];
      out_count++;
      if (o_sof) sof_count++;
      check_val("o_valid", 1, exp_valid[idx]);
      check_val("o_sof", o_sof, exp_sof[idx]);
      check_val("o_eof", o_eof, exp_eof[idx]);
      check_val("o_data.re", o_data.re, ant_re[0][idx]);
      check_val("o_data.im", o_data.im, ant_im[0][idx]);
    end else begin
      check_val("o_sof", o_sof, 0);  // Strobes only ride on a valid output
      check_val("o_eof", o_eof, 0);
    end
  end

  task automatic write_setting(input logic [7:0] addr, input longint value);
    @(posedge clk);
    i_set_stb  <= 1'b1;
    i_set_addr <= addr;
    i_set_data <= 32'(value);
  endtask

  task automatic make_samples(input row_t row);
    int sym_re [WINDOW_LEN];
    int sym_im [WINDOW_LEN];
    int c_re;
    int c_im;
    for (int k = 0; k < WINDOW_LEN; k++) begin
      sym_re[k] = rnd(row.pre_amp);
      sym_im[k] = rnd(row.pre_amp);
    end
    for (int n = 0; n < row.total; n++) begin
      c_re = 0;
      c_im = 0;
      if (n >= row.pre_start && n < row.pre_start + row.repeats * WINDOW_LEN) begin
        c_re = sym_re[(n - row.pre_start) % WINDOW_LEN];
        c_im = sym_im[(n - row.pre_start) % WINDOW_LEN];
      end
      ant_re[0][n] = c_re + rnd(row.noise_amp);
      ant_im[0][n] = c_im + rnd(row.noise_amp);
      ant_re[1][n] = (c_re * 3) / 4 + rnd(row.noise_amp);  // Weaker second path
      ant_im[1][n] = (c_im * 3) / 4 + rnd(row.noise_amp);
    end
  endtask

  task automatic run_row(input row_t row);
    int exp_count;
    make_samples(row);
    exp_count = build_expected(row.total, row.thresh, row.min_e, row.plateau, row.frame_len);
    @(posedge clk);
    i_rst <= 1'b1;
    repeat (2) @(posedge clk);
    i_rst <= 1'b0;
    idx_at.delete();
    out_count = 0;
    sof_count = 0;
    write_setting(sc_cfg_pkg::ADDR_THRESHOLD, row.thresh);
    write_setting(sc_cfg_pkg::ADDR_PLATEAU, row.plateau);
    write_setting(sc_cfg_pkg::ADDR_FRAME, row.frame_len);
    write_setting(sc_cfg_pkg::ADDR_MIN_ENERGY, row.min_e);
    @(posedge clk);
    i_set_stb <= 1'b0;
    for (int n = 0; n < row.total; n++) begin
      if (row.gap_period > 0 && n > 0 && n % row.gap_period == 0) begin
        @(posedge clk);
        i_valid <= 1'b0;
      end
      @(posedge clk);
      i_valid <= 1'b1;
      drv_idx <= n;
      for (int a = 0; a < NUM_ANT; a++) begin
        i_samples[a].re <= 16'(ant_re[a][n]);
        i_samples[a].im <= 16'(ant_im[a][n]);
      end
    end
    @(posedge clk);
    i_valid <= 1'b0;
    repeat (LATENCY + 3) @(posedge clk);  // Drain the pipeline
    check_val("output_count", out_count, exp_count);
    check_val("frame_seen", sof_count > 0, row.expect_frame);
  endtask

  initial begin
    // amp, start, repeats, noise, thresh, plateau, frame, min_e, total, gap, frame
    rows[0] = '{0, 0, 0, 200, 'h30, 8, 32, 1000, 200, 0, 0};
    rows[1] = '{1000, 40, 6, 300, 'h30, 8, 32, 1000, 260, 0, 1};
    rows[2] = '{1000, 40, 6, 300, 'hFF, 8, 32, 1000, 260, 0, 0};
    rows[3] = '{1000, 40, 6, 300, 'h30, 8, 32, 64'h7FFF_FFFF, 260, 0, 0};
    rows[4] = '{1000, 40, 6, 300, 'h30, 250, 32, 1000, 260, 0, 0};
    rows[5] = '{1000, 40, 6, 300, 'h30, 4, 20, 1000, 260, 5, 1};
    cycle_limit = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      cycle_limit += rows[r].total + 20;
      if (rows[r].gap_period > 0) cycle_limit += rows[r].total / rows[r].gap_period;
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(rows[r]);
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule
